// File: Bender.yml
package:
  name: or_tree

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/or_tree_req_pkg.sv
      - rtl/or_tree_node_pkg.sv
      - rtl/or_tree_ram.sv
      - rtl/alloc_search.sv
      - rtl/free_check.sv
      - rtl/or_tree_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/or_tree_tb.sv

// File: files.f
+incdir+rtl
rtl/or_tree_req_pkg.sv
rtl/or_tree_node_pkg.sv
rtl/or_tree_ram.sv
rtl/alloc_search.sv
rtl/free_check.sv
rtl/or_tree_top.sv
verification/or_tree_tb.sv

// File: rtl/alloc_search.sv
// first-fit search of a node for a free block
// returns the slot, the no-space flag and the updated node
`default_nettype none

`include "or_tree_cfg.svh"

module alloc_search (
    input  or_tree_node_pkg::node_t         node,
    input  or_tree_req_pkg::req_size_e      size,
    output logic [`SLOT_WIDTH-1:0]          slot,
    output logic                            no_space,
    output or_tree_node_pkg::node_t         new_node
);

    always_comb begin
        logic [7:0] busy;
        logic [`SLOT_WIDTH-1:0] blk;
        logic [`SLOT_WIDTH-1:0] base;
        logic found;
        or_tree_node_pkg::leaves_t grown;

        // bit i of busy is block i of the chosen level
        // positions past the level width count as taken
        busy = '1;
        case (size)
            or_tree_req_pkg::size_4k: begin
                busy[0] = node[or_tree_node_pkg::TOP_BIT];
            end
            or_tree_req_pkg::size_2k: begin
                for (int i = 0; i < 2; i++) begin
                    busy[i] = node[or_tree_node_pkg::HALF_LSB + 1 - i];
                end
            end
            or_tree_req_pkg::size_1k: begin
                for (int i = 0; i < 4; i++) begin
                    busy[i] = node[or_tree_node_pkg::QUARTER_LSB + 3 - i];
                end
            end
            default: begin
                for (int i = 0; i < 8; i++) begin
                    busy[i] = node[or_tree_node_pkg::LEAF_LSB + 7 - i];
                end
            end
        endcase

        // lowest clear block wins
        found = 1'b0;
        blk = '0;
        for (int i = 0; i < 8; i++) begin
            if (!found && !busy[i]) begin
                found = 1'b1;
                blk = i[`SLOT_WIDTH-1:0];
            end
        end

        base = blk << or_tree_node_pkg::size_log2(size);
        grown = node[7:0] | or_tree_node_pkg::block_leaves(base, size);

        slot = base;
        no_space = !found;
        new_node = or_tree_node_pkg::rebuild_node(grown);
    end

endmodule

`default_nettype wire

// File: rtl/free_check.sv
// check of a free request against the node
// returns the fail reason and the node with the block released
`default_nettype none

`include "or_tree_cfg.svh"

module free_check (
    input  or_tree_node_pkg::node_t         node,
    input  wire [`SLOT_WIDTH-1:0]           slot,
    input  or_tree_req_pkg::req_size_e      size,
    output or_tree_req_pkg::fail_reason_e   fail_reason,
    output or_tree_node_pkg::node_t         new_node
);

    or_tree_node_pkg::leaves_t mask;
    or_tree_node_pkg::leaves_t leaves;
    logic [1:0] shift;
    logic misaligned;
    logic partly_free;

    assign leaves = node[7:0];
    assign shift = or_tree_node_pkg::size_log2(size);
    assign mask = or_tree_node_pkg::block_leaves(slot, size);

    // slot must be a whole multiple of the block size in pages
    assign misaligned = ((slot >> shift) << shift) != slot;

    // every leaf of the block has to be in use
    assign partly_free = (leaves & mask) != mask;

    always_comb begin
        if (misaligned) begin
            fail_reason = or_tree_req_pkg::fail_misaligned;
        end else if (partly_free) begin
            fail_reason = or_tree_req_pkg::fail_not_allocated;
        end else begin
            fail_reason = or_tree_req_pkg::fail_none;
        end
    end

    // ancestors come back from the remaining leaves
    assign new_node = or_tree_node_pkg::rebuild_node(leaves & ~mask);

endmodule

`default_nettype wire

// File: rtl/or_tree_cfg.svh
// widths of the buddy-tree node update stage
// tree, page, request tag, AT and node word sizes
`ifndef OR_TREE_CFG_SVH
`define OR_TREE_CFG_SVH

// one node word per tree index
`define OR_TREE_INDEX_WIDTH 12
// tree index followed by a 3-bit slot
`define PAGE_IDX_WIDTH 15
`define REQ_ID_WIDTH 8

// AT row is the high half of the tree index, column the low half
`define AT_TREE_INDEX_WIDTH 6

`define NODE_WIDTH 15
`define SLOT_WIDTH 3
`define AT_BITS 4

// encoding width of the request size and fail reason fields
`define REQ_FIELD_WIDTH 2

`endif

// File: rtl/or_tree_node_pkg.sv
// node word layout of a buddy tree
// leaf masks, upper level rebuild and level-full summary
`default_nettype none

`include "or_tree_cfg.svh"

package or_tree_node_pkg;

    typedef logic [`NODE_WIDTH-1:0] node_t;
    typedef logic [7:0] leaves_t;

    // slot 0 sits at the msb of every level
    localparam int LEAF_LSB    = 0;
    localparam int QUARTER_LSB = 8;
    localparam int HALF_LSB    = 12;
    localparam int TOP_BIT     = 14;

    // log2 of the block size counted in 512 B pages
    function automatic logic [1:0] size_log2(input or_tree_req_pkg::req_size_e size);
        return 2'd3 - size;
    endfunction

    function automatic leaves_t block_leaves(input logic [`SLOT_WIDTH-1:0] slot,
                                             input or_tree_req_pkg::req_size_e size);
        logic [3:0] pages;
        leaves_t head;
        pages = 4'd1 << size_log2(size);
        // run of ones at the top, then moved down to the slot
        head = ~(8'hff >> pages);
        return head >> slot;
    endfunction

    function automatic node_t rebuild_node(input leaves_t leaves);
        logic [3:0] quarters;
        logic [1:0] halves;
        for (int i = 0; i < 4; i++) begin
            quarters[i] = leaves[2*i+1] | leaves[2*i];
        end
        halves[1] = quarters[3] | quarters[2];
        halves[0] = quarters[1] | quarters[0];
        return {halves[1] | halves[0], halves, quarters, leaves};
    endfunction

    // bit 3 is the 4K bit, lower bits flag a completely used level
    function automatic logic [`AT_BITS-1:0] level_full(input node_t node);
        return {node[TOP_BIT], &node[HALF_LSB +: 2], &node[QUARTER_LSB +: 4],
                &node[LEAF_LSB +: 8]};
    endfunction

endpackage

`default_nettype wire

// File: rtl/or_tree_ram.sv
// node memory, one word per tree
// one write port and two registered read ports
`default_nettype none

`include "or_tree_cfg.svh"

module or_tree_ram (
    input  wire                              clk,
    input  wire                              write_en,
    input  wire [`OR_TREE_INDEX_WIDTH-1:0]   write_addr,
    input  or_tree_node_pkg::node_t          write_data,
    input  wire [`OR_TREE_INDEX_WIDTH-1:0]   read_addr_alloc,
    input  wire [`OR_TREE_INDEX_WIDTH-1:0]   read_addr_free,
    output or_tree_node_pkg::node_t          read_data_alloc,
    output or_tree_node_pkg::node_t          read_data_free
);

    // every tree starts empty
    or_tree_node_pkg::node_t mem [0:(1 << `OR_TREE_INDEX_WIDTH)-1] = '{default: '0};

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // alloc and free lookups each have their own output register
    always_ff @(posedge clk) begin
        read_data_alloc <= mem[read_addr_alloc];
    end

    always_ff @(posedge clk) begin
        read_data_free <= mem[read_addr_free];
    end

endmodule

`default_nettype wire

// File: rtl/or_tree_req_pkg.sv
// request vocabulary of the node update stage
// block sizes and fail reasons
`default_nettype none

`include "or_tree_cfg.svh"

package or_tree_req_pkg;

    // block size of an alloc or free, largest first
    typedef enum logic [`REQ_FIELD_WIDTH-1:0] {
        size_4k  = 2'd0,
        size_2k  = 2'd1,
        size_1k  = 2'd2,
        size_512 = 2'd3
    } req_size_e;

    typedef enum logic [`REQ_FIELD_WIDTH-1:0] {
        fail_none          = 2'd0,
        fail_no_space      = 2'd1,
        fail_misaligned    = 2'd2,
        fail_not_allocated = 2'd3
    } fail_reason_e;

endpackage

`default_nettype wire

// File: rtl/or_tree_top.sv
// node update stage of the buddy-tree page allocator
// three-stage alloc/free pipeline, node write back,
// responses and AT-tree update
`default_nettype none

`include "or_tree_cfg.svh"

module or_tree_top (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 alloc_valid,
    input  wire [`REQ_ID_WIDTH-1:0]             alloc_id,
    input  wire [`OR_TREE_INDEX_WIDTH-1:0]      alloc_tree_index,
    input  or_tree_req_pkg::req_size_e          alloc_size,
    input  wire                                 free_valid,
    input  wire [`REQ_ID_WIDTH-1:0]             free_id,
    input  wire [`PAGE_IDX_WIDTH-1:0]           free_page_index,
    input  or_tree_req_pkg::req_size_e          free_size,
    output logic                                alloc_rsp_valid,
    output logic [`REQ_ID_WIDTH-1:0]            alloc_rsp_id,
    output logic [`PAGE_IDX_WIDTH-1:0]          alloc_rsp_page_idx,
    output logic                                alloc_rsp_fail,
    output or_tree_req_pkg::fail_reason_e       alloc_rsp_fail_reason,
    output logic                                free_rsp_valid,
    output logic [`REQ_ID_WIDTH-1:0]            free_rsp_id,
    output logic                                free_rsp_fail,
    output or_tree_req_pkg::fail_reason_e       free_rsp_fail_reason,
    output logic                                at_update_valid,
    output logic [`AT_TREE_INDEX_WIDTH-1:0]     at_update_row,
    output logic [`AT_TREE_INDEX_WIDTH-1:0]     at_update_col,
    output logic [`AT_BITS-1:0]                 at_update_bits
);

    // stage 1 while the node word is read
    logic                               alloc_valid_q1, free_valid_q1;
    logic [`REQ_ID_WIDTH-1:0]           alloc_id_q1, free_id_q1;
    logic [`OR_TREE_INDEX_WIDTH-1:0]    alloc_tree_q1;
    logic [`PAGE_IDX_WIDTH-1:0]         free_page_q1;
    or_tree_req_pkg::req_size_e         alloc_size_q1, free_size_q1;

    // stage 2 holds the search or check result for the write
    logic                               alloc_valid_q2, free_valid_q2;
    logic [`REQ_ID_WIDTH-1:0]           alloc_id_q2, free_id_q2;
    logic [`OR_TREE_INDEX_WIDTH-1:0]    alloc_tree_q2, free_tree_q2;
    logic [`SLOT_WIDTH-1:0]             alloc_slot_q2;
    logic                               alloc_no_space_q2;
    or_tree_req_pkg::fail_reason_e      free_fail_q2;
    or_tree_node_pkg::node_t            alloc_node_q2, free_node_q2;

    or_tree_node_pkg::node_t            read_data_alloc, read_data_free;
    logic [`SLOT_WIDTH-1:0]             search_slot;
    logic                               search_no_space;
    or_tree_node_pkg::node_t            search_node, check_node;
    or_tree_req_pkg::fail_reason_e      check_fail;

    logic                               write_en;
    logic [`OR_TREE_INDEX_WIDTH-1:0]    write_addr;
    or_tree_node_pkg::node_t            write_data;

    or_tree_ram u_ram (
        .clk             (clk),
        .write_en        (write_en),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .read_addr_alloc (alloc_tree_index),
        .read_addr_free  (free_page_index[`PAGE_IDX_WIDTH-1:`SLOT_WIDTH]),
        .read_data_alloc (read_data_alloc),
        .read_data_free  (read_data_free)
    );

    alloc_search u_alloc_search (
        .node     (read_data_alloc),
        .size     (alloc_size_q1),
        .slot     (search_slot),
        .no_space (search_no_space),
        .new_node (search_node)
    );

    free_check u_free_check (
        .node        (read_data_free),
        .slot        (free_page_q1[`SLOT_WIDTH-1:0]),
        .size        (free_size_q1),
        .fail_reason (check_fail),
        .new_node    (check_node)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_valid_q1  <= 1'b0;
            free_valid_q1   <= 1'b0;
            alloc_valid_q2  <= 1'b0;
            free_valid_q2   <= 1'b0;
            alloc_rsp_valid <= 1'b0;
            free_rsp_valid  <= 1'b0;
            at_update_valid <= 1'b0;
        end else begin
            alloc_valid_q1  <= alloc_valid;
            free_valid_q1   <= free_valid;
            alloc_valid_q2  <= alloc_valid_q1;
            free_valid_q2   <= free_valid_q1;
            alloc_rsp_valid <= alloc_valid_q2;
            free_rsp_valid  <= free_valid_q2;
            // failed requests leave the AT tree alone
            at_update_valid <= write_en;
        end
    end

    always_ff @(posedge clk) begin
        alloc_id_q1       <= alloc_id;
        alloc_tree_q1     <= alloc_tree_index;
        alloc_size_q1     <= alloc_size;
        free_id_q1        <= free_id;
        free_page_q1      <= free_page_index;
        free_size_q1      <= free_size;

        alloc_id_q2       <= alloc_id_q1;
        alloc_tree_q2     <= alloc_tree_q1;
        alloc_slot_q2     <= search_slot;
        alloc_no_space_q2 <= search_no_space;
        alloc_node_q2     <= search_node;
        free_id_q2        <= free_id_q1;
        free_tree_q2      <= free_page_q1[`PAGE_IDX_WIDTH-1:`SLOT_WIDTH];
        free_fail_q2      <= check_fail;
        free_node_q2      <= check_node;
    end

    // alloc and free never share a stage, so one write port serves both
    assign write_en = (alloc_valid_q2 && !alloc_no_space_q2) ||
                      (free_valid_q2 && free_fail_q2 == or_tree_req_pkg::fail_none);
    assign write_addr = alloc_valid_q2 ? alloc_tree_q2 : free_tree_q2;
    assign write_data = alloc_valid_q2 ? alloc_node_q2 : free_node_q2;

    always_ff @(posedge clk) begin
        alloc_rsp_id          <= alloc_id_q2;
        alloc_rsp_page_idx    <= {alloc_tree_q2, alloc_slot_q2};
        alloc_rsp_fail        <= alloc_no_space_q2;
        alloc_rsp_fail_reason <= alloc_no_space_q2 ? or_tree_req_pkg::fail_no_space
                                                   : or_tree_req_pkg::fail_none;
        free_rsp_id           <= free_id_q2;
        free_rsp_fail         <= free_fail_q2 != or_tree_req_pkg::fail_none;
        free_rsp_fail_reason  <= free_fail_q2;
        // row and column split the tree index in two halves
        at_update_row  <= write_addr[`OR_TREE_INDEX_WIDTH-1 -: `AT_TREE_INDEX_WIDTH];
        at_update_col  <= write_addr[`AT_TREE_INDEX_WIDTH-1:0];
        at_update_bits <= or_tree_node_pkg::level_full(write_data);
    end

endmodule

`default_nettype wire

// File: verification/or_tree_tb.sv
// testbench of the buddy-tree node update stage
// leaf model per tree, directed tests and a random mix
`default_nettype none

`include "or_tree_cfg.svh"

module or_tree_tb;

    logic clk = 1'b0;
    logic rst_n;
    logic alloc_valid, free_valid;
    logic [`REQ_ID_WIDTH-1:0] alloc_id, free_id;
    logic [`OR_TREE_INDEX_WIDTH-1:0] alloc_tree_index;
    logic [`PAGE_IDX_WIDTH-1:0] free_page_index;
    or_tree_req_pkg::req_size_e alloc_size, free_size;
    logic alloc_rsp_valid, alloc_rsp_fail, free_rsp_valid, free_rsp_fail;
    logic [`REQ_ID_WIDTH-1:0] alloc_rsp_id, free_rsp_id;
    logic [`PAGE_IDX_WIDTH-1:0] alloc_rsp_page_idx;
    or_tree_req_pkg::fail_reason_e alloc_rsp_fail_reason, free_rsp_fail_reason;
    logic at_update_valid;
    logic [`AT_TREE_INDEX_WIDTH-1:0] at_update_row, at_update_col;
    logic [`AT_BITS-1:0] at_update_bits;

    // model leaves, bit 7 is slot 0
    logic [7:0] model_leaves [0:(1 << `OR_TREE_INDEX_WIDTH)-1];
    logic [`OR_TREE_INDEX_WIDTH-1:0] rand_trees [0:3];
    logic [`REQ_ID_WIDTH-1:0] next_id;
    integer errors;
    integer seed;

    always #5 clk = ~clk;

    or_tree_top dut (.*);

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [7:0] span(input int slot, input int pages);
        logic [7:0] m;
        m = '0;
        for (int i = slot; i < slot + pages && i < 8; i++) begin
            m[7-i] = 1'b1;
        end
        return m;
    endfunction

    // first block of the size whose leaves are all clear, -1 when none
    function automatic int find_slot(input logic [7:0] lv, input int pages);
        for (int s = 0; s < 8; s += pages) begin
            if ((lv & span(s, pages)) == 8'h00) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic logic [3:0] full_bits(input logic [7:0] lv);
        logic [3:0] q;
        for (int i = 0; i < 4; i++) begin
            q[i] = (lv & span(2 * i, 2)) != 8'h00;
        end
        return {lv != 8'h00, (lv[7:4] != 4'h0) && (lv[3:0] != 4'h0), &q, &lv};
    endfunction

    task automatic wait_response(input bit for_alloc, output bit seen);
        seen = 1'b0;
        for (int n = 0; n < 10 && !seen; n++) begin
            @(negedge clk);
            seen = for_alloc ? alloc_rsp_valid : free_rsp_valid;
        end
        if (!seen) begin
            $display("ERROR: no %s response within 10 cycles", for_alloc ? "alloc" : "free");
            errors++;
        end
    endtask

    task automatic check_at(input logic [`OR_TREE_INDEX_WIDTH-1:0] tree, input bit updated);
        check("at_update_valid", at_update_valid, updated);
        if (updated) begin
            check("at_update_row", at_update_row, tree >> `AT_TREE_INDEX_WIDTH);
            check("at_update_col", at_update_col, tree % (1 << `AT_TREE_INDEX_WIDTH));
            check("at_update_bits", at_update_bits, full_bits(model_leaves[tree]));
        end
    endtask

    task automatic do_alloc(input logic [`OR_TREE_INDEX_WIDTH-1:0] tree,
                            input or_tree_req_pkg::req_size_e size);
        int pages;
        int slot;
        bit seen;
        pages = 8 >> size;
        slot = find_slot(model_leaves[tree], pages);
        if (slot >= 0) begin
            model_leaves[tree] = model_leaves[tree] | span(slot, pages);
        end
        @(posedge clk);
        alloc_valid <= 1'b1;
        alloc_id <= next_id;
        alloc_tree_index <= tree;
        alloc_size <= size;
        @(posedge clk);
        alloc_valid <= 1'b0;
        wait_response(1'b1, seen);
        if (seen) begin
            check("alloc_rsp_id", alloc_rsp_id, next_id);
            check("alloc_rsp_fail", alloc_rsp_fail, slot < 0);
            if (slot < 0) begin
                check("alloc_rsp_fail_reason", alloc_rsp_fail_reason,
                      or_tree_req_pkg::fail_no_space);
            end else begin
                check("alloc_rsp_fail_reason", alloc_rsp_fail_reason, or_tree_req_pkg::fail_none);
                check("alloc_rsp_page_idx", alloc_rsp_page_idx, tree * 8 + slot);
            end
            check_at(tree, slot >= 0);
        end
        next_id++;
    endtask

    task automatic do_free(input logic [`OR_TREE_INDEX_WIDTH-1:0] tree, input int slot,
                           input or_tree_req_pkg::req_size_e size);
        int pages;
        logic [7:0] mask;
        or_tree_req_pkg::fail_reason_e reason;
        bit seen;
        pages = 8 >> size;
        mask = span(slot, pages);
        if (slot % pages != 0) begin
            reason = or_tree_req_pkg::fail_misaligned;
        end else if ((model_leaves[tree] & mask) != mask) begin
            reason = or_tree_req_pkg::fail_not_allocated;
        end else begin
            reason = or_tree_req_pkg::fail_none;
            model_leaves[tree] = model_leaves[tree] & ~mask;
        end
        @(posedge clk);
        free_valid <= 1'b1;
        free_id <= next_id;
        free_page_index <= tree * 8 + slot;
        free_size <= size;
        @(posedge clk);
        free_valid <= 1'b0;
        wait_response(1'b0, seen);
        if (seen) begin
            check("free_rsp_id", free_rsp_id, next_id);
            check("free_rsp_fail", free_rsp_fail, reason != or_tree_req_pkg::fail_none);
            check("free_rsp_fail_reason", free_rsp_fail_reason, reason);
            check_at(tree, reason == or_tree_req_pkg::fail_none);
        end
        next_id++;
    endtask

    task automatic random_mix(input int count);
        logic [31:0] r;
        int slot;
        for (int k = 0; k < count; k++) begin
            r = $random(seed);
            slot = r[5:3];
            // keep about half the frees aligned so they can succeed
            if (r[8]) begin
                slot = slot - slot % (8 >> r[2:1]);
            end
            if (r[0]) begin
                do_alloc(rand_trees[r[7:6]], or_tree_req_pkg::req_size_e'(r[2:1]));
            end else begin
                do_free(rand_trees[r[7:6]], slot, or_tree_req_pkg::req_size_e'(r[2:1]));
            end
        end
    endtask

    initial begin
        errors = 0;
        seed = 32'h178d_916c;
        next_id = '0;
        rand_trees = '{12'h0c3, 12'h7c2, 12'hfff, 12'h040};
        foreach (model_leaves[i]) begin
            model_leaves[i] = 8'h00;
        end
        rst_n <= 1'b0;
        alloc_valid <= 1'b0;
        alloc_id <= '0;
        alloc_tree_index <= '0;
        alloc_size <= or_tree_req_pkg::size_4k;
        free_valid <= 1'b0;
        free_id <= '0;
        free_page_index <= '0;
        free_size <= or_tree_req_pkg::size_4k;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // quiet outputs with no requests
        repeat (4) begin
            @(negedge clk);
            check("alloc_rsp_valid", alloc_rsp_valid, 1'b0);
            check("free_rsp_valid", free_rsp_valid, 1'b0);
            check("at_update_valid", at_update_valid, 1'b0);
        end

        repeat (9) do_alloc(12'd5, or_tree_req_pkg::size_512);

        do_alloc(12'd9, or_tree_req_pkg::size_1k);
        do_alloc(12'd9, or_tree_req_pkg::size_2k);
        do_alloc(12'd9, or_tree_req_pkg::size_512);

        do_free(12'd9, 0, or_tree_req_pkg::size_1k);
        do_alloc(12'd9, or_tree_req_pkg::size_512);

        do_free(12'd9, 2, or_tree_req_pkg::size_2k);
        do_free(12'd9, 1, or_tree_req_pkg::size_512);
        do_alloc(12'd9, or_tree_req_pkg::size_512);

        random_mix(200);

        repeat (4) @(posedge clk);
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
